//--- hdl/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// bus widths in bits
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// words per cache line, lowest word at the line base
`define ICACHE_LINE_WORDS 4

// sets per way
`define ICACHE_SETS 16

// associativity, way select and LRU assume two
`define ICACHE_WAYS 2

`endif

//--- hdl/icache_addr_pkg.sv
`include "icache_settings.svh"

package icache_addr_pkg;

   localparam int LINE_BYTES = `ICACHE_LINE_WORDS * `ICACHE_WORD_W / 8;
   localparam int OFFSET_W = $clog2(LINE_BYTES);
   localparam int INDEX_W = $clog2(`ICACHE_SETS);
   localparam int TAG_W = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
   localparam int WORD_SEL_W = $clog2(`ICACHE_LINE_WORDS);
   localparam int BYTE_SEL_W = $clog2(`ICACHE_WORD_W / 8);

   typedef logic [OFFSET_W-1:0] offset_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [WORD_SEL_W-1:0] word_sel_t;
   typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
   typedef logic [`ICACHE_WORD_W-1:0] word_t;
   typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0] line_t;

   typedef struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
   } addr_fields_t;

   function automatic addr_fields_t split_addr(addr_t addr);
      addr_fields_t f;
      f.tag = addr[`ICACHE_ADDR_W-1:INDEX_W+OFFSET_W];
      f.index = addr[INDEX_W+OFFSET_W-1:OFFSET_W];
      f.offset = addr[OFFSET_W-1:0];
      return f;
   endfunction

   // word number inside the line, byte lanes dropped
   function automatic word_sel_t word_of(offset_t offset);
      return offset[OFFSET_W-1:BYTE_SEL_W];
   endfunction

   function automatic addr_t line_base(addr_t addr);
      return {addr[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   endfunction

endpackage

//--- hdl/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

   typedef enum logic [0:0] {
      op_read       = 1'b0,
      op_invalidate = 1'b1
   } cache_op_e;

   // idle, array read, tag compare, line refill, way write
   typedef enum logic [2:0] {
      st_idle   = 3'd0,
      st_read   = 3'd1,
      st_lookup = 3'd2,
      st_refill = 3'd3,
      st_fill   = 3'd4
   } ctrl_state_e;

   typedef struct packed {
      cache_op_e              op;
      icache_addr_pkg::addr_t addr;
   } cpu_req_t;

   typedef struct packed {
      cache_op_e              op;
      icache_addr_pkg::word_t data;
   } cpu_resp_t;

   // always line aligned
   typedef struct packed {
      icache_addr_pkg::addr_t addr;
   } mem_req_t;

   // valid 0 clears the line, valid 1 also loads tag and data
   typedef struct packed {
      logic                    en;
      icache_addr_pkg::index_t index;
      icache_addr_pkg::tag_t   tag;
      logic                    valid;
      icache_addr_pkg::line_t  line;
   } way_write_t;

endpackage

//--- hdl/icache_way.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way (
   input  logic                        clk,
   input  logic                        reset,
   input  icache_addr_pkg::index_t     rd_index,
   input  icache_addr_pkg::tag_t       lookup_tag,
   input  icache_addr_pkg::word_sel_t  word_sel,
   input  icache_ctrl_pkg::way_write_t wr,
   output logic                        way_hit,
   output icache_addr_pkg::word_t      way_word
);

   import icache_addr_pkg::*;

   tag_t                    tag_mem [`ICACHE_SETS];
   line_t                   data_mem [`ICACHE_SETS];
   logic [`ICACHE_SETS-1:0] valid_q;

   tag_t  rd_tag_q;
   line_t rd_line_q;
   logic  rd_valid_q;

   // tag and data only change on a line fill
   always_ff @(posedge clk) begin
      if (wr.en && wr.valid) begin
         tag_mem[wr.index] <= wr.tag;
         data_mem[wr.index] <= wr.line;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else if (wr.en) begin
         valid_q[wr.index] <= wr.valid;
      end
   end

   // synchronous read, result one cycle after rd_index
   always_ff @(posedge clk) begin
      rd_tag_q <= tag_mem[rd_index];
      rd_line_q <= data_mem[rd_index];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= valid_q[rd_index];
      end
   end

   assign way_hit = rd_valid_q && (rd_tag_q == lookup_tag);

   // word lanes are in address order inside the line
   assign way_word = rd_line_q[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

//--- hdl/icache_way_select.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way_select (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`ICACHE_WAYS-1:0] way_hit,
   input  icache_addr_pkg::word_t  way_word [`ICACHE_WAYS],
   input  icache_addr_pkg::index_t rd_index,
   input  logic                    lru_touch,
   output logic                    hit,
   output icache_addr_pkg::word_t  hit_word,
   output logic                    victim
);

   import icache_addr_pkg::*;

   localparam int WAY_W = $clog2(`ICACHE_WAYS);

   // per set, the way to replace next
   logic [`ICACHE_SETS-1:0] lru_q;
   logic [WAY_W-1:0]        hit_way;

   // at most one way hits, so the masked words can be ORed
   always_comb begin
      hit_way = '0;
      hit_word = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
         if (way_hit[w]) begin
            hit_way = WAY_W'(w);
         end
         hit_word = hit_word | ({`ICACHE_WORD_W{way_hit[w]}} & way_word[w]);
      end
   end

   assign hit = |way_hit;
   assign victim = lru_q[rd_index];

   // point at the way that did not hit
   always_ff @(posedge clk) begin
      if (reset) begin
         lru_q <= '0;
      end else if (lru_touch) begin
         lru_q[rd_index] <= ~hit_way;
      end
   end

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl (
   input  logic                        clk,
   input  logic                        reset,
   input  icache_ctrl_pkg::cpu_req_t   cpu_req,
   input  logic                        req_valid,
   output logic                        req_ready,
   output logic                        resp_valid,
   output icache_ctrl_pkg::cache_op_e  resp_op,
   input  logic                        resp_ready,
   output icache_ctrl_pkg::mem_req_t   mem_req,
   output logic                        mem_valid,
   input  logic                        mem_ready,
   input  icache_addr_pkg::word_t      mem_rdata,
   input  logic                        mem_rdata_valid,
   output icache_addr_pkg::index_t     rd_index,
   output icache_addr_pkg::tag_t       lookup_tag,
   output icache_addr_pkg::word_sel_t  word_sel,
   output icache_ctrl_pkg::way_write_t way_wr [`ICACHE_WAYS],
   input  logic                        hit,
   input  logic                        victim,
   output logic                        lru_touch
);

   import icache_addr_pkg::*;
   import icache_ctrl_pkg::*;

   localparam word_sel_t LAST_WORD = word_sel_t'(`ICACHE_LINE_WORDS - 1);

   ctrl_state_e  state;
   ctrl_state_e  state_next;
   cpu_req_t     req_q;
   addr_fields_t req_f;
   logic         is_inv;
   logic         mem_pend_q;
   word_sel_t    fill_cnt;
   line_t        line_q;
   logic         fill_done;
   logic         inv_wr;
   logic         fill_wr;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (req_valid) begin
               state_next = st_read;
            end
         end
         st_read: begin
            // invalidate answers here, reads go on to compare tags
            if (!is_inv) begin
               state_next = st_lookup;
            end else if (resp_ready) begin
               state_next = st_idle;
            end
         end
         st_lookup: begin
            if (!hit) begin
               state_next = st_refill;
            end else if (resp_ready) begin
               state_next = st_idle;
            end
         end
         st_refill: begin
            if (fill_done) begin
               state_next = st_fill;
            end
         end
         st_fill: begin
            state_next = st_read;
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   // request held for the whole transaction
   always_ff @(posedge clk) begin
      if (state == st_idle && req_valid) begin
         req_q <= cpu_req;
      end
   end

   // memory request stays up until accepted
   always_ff @(posedge clk) begin
      if (reset) begin
         mem_pend_q <= 1'b0;
      end else if (state == st_lookup && !hit) begin
         mem_pend_q <= 1'b1;
      end else if (mem_ready) begin
         mem_pend_q <= 1'b0;
      end
   end

   // strobe count, wraps back to 0 on the last word
   always_ff @(posedge clk) begin
      if (reset) begin
         fill_cnt <= '0;
      end else if (state == st_refill && mem_rdata_valid) begin
         fill_cnt <= fill_cnt + word_sel_t'(1);
      end
   end

   // words enter at the top, first word ends up lowest
   always_ff @(posedge clk) begin
      if (state == st_refill && mem_rdata_valid) begin
         line_q <= {mem_rdata, line_q[$bits(line_t)-1:`ICACHE_WORD_W]};
      end
   end

   assign fill_done = state == st_refill && mem_rdata_valid && fill_cnt == LAST_WORD;

   assign req_f = split_addr(req_q.addr);
   assign is_inv = req_q.op == op_invalidate;

   assign req_ready = state == st_idle;
   assign resp_valid = (state == st_read && is_inv) || (state == st_lookup && hit);
   assign resp_op = req_q.op;
   assign lru_touch = state == st_lookup && hit && resp_ready;

   assign mem_valid = mem_pend_q;
   assign mem_req.addr = line_base(req_q.addr);

   assign rd_index = req_f.index;
   assign lookup_tag = req_f.tag;
   assign word_sel = word_of(req_f.offset);

   assign inv_wr = state == st_read && is_inv;
   assign fill_wr = state == st_fill;

   // refill goes to the LRU way, invalidate picks the way by address bit 0
   always_comb begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
         way_wr[w].en = (fill_wr && int'(victim) == w) ||
                        (inv_wr && int'(req_q.addr[0]) == w);
         way_wr[w].index = req_f.index;
         way_wr[w].tag = req_f.tag;
         way_wr[w].valid = fill_wr;
         way_wr[w].line = line_q;
      end
   end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
   input  logic                       clk,
   input  logic                       reset,
   input  icache_ctrl_pkg::cpu_req_t  cpu_req,
   input  logic                       req_valid,
   output logic                       req_ready,
   output icache_ctrl_pkg::cpu_resp_t cpu_resp,
   output logic                       resp_valid,
   input  logic                       resp_ready,
   output icache_ctrl_pkg::mem_req_t  mem_req,
   output logic                       mem_valid,
   input  logic                       mem_ready,
   input  icache_addr_pkg::word_t     mem_rdata,
   input  logic                       mem_rdata_valid
);

   import icache_addr_pkg::*;
   import icache_ctrl_pkg::*;

   index_t                  rd_index;
   tag_t                    lookup_tag;
   word_sel_t               word_sel;
   way_write_t              way_wr [`ICACHE_WAYS];
   logic [`ICACHE_WAYS-1:0] way_hit;
   word_t                   way_word [`ICACHE_WAYS];
   logic                    hit;
   word_t                   hit_word;
   logic                    victim;
   logic                    lru_touch;
   cache_op_e               resp_op;

   icache_ctrl u_ctrl (
      .clk             (clk),
      .reset           (reset),
      .cpu_req         (cpu_req),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .resp_valid      (resp_valid),
      .resp_op         (resp_op),
      .resp_ready      (resp_ready),
      .mem_req         (mem_req),
      .mem_valid       (mem_valid),
      .mem_ready       (mem_ready),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .rd_index        (rd_index),
      .lookup_tag      (lookup_tag),
      .word_sel        (word_sel),
      .way_wr          (way_wr),
      .hit             (hit),
      .victim          (victim),
      .lru_touch       (lru_touch)
   );

   for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      icache_way u_way (
         .clk        (clk),
         .reset      (reset),
         .rd_index   (rd_index),
         .lookup_tag (lookup_tag),
         .word_sel   (word_sel),
         .wr         (way_wr[w]),
         .way_hit    (way_hit[w]),
         .way_word   (way_word[w])
      );
   end

   icache_way_select u_way_select (
      .clk       (clk),
      .reset     (reset),
      .way_hit   (way_hit),
      .way_word  (way_word),
      .rd_index  (rd_index),
      .lru_touch (lru_touch),
      .hit       (hit),
      .hit_word  (hit_word),
      .victim    (victim)
   );

   assign cpu_resp.op = resp_op;
   // invalidate replies carry no data
   assign cpu_resp.data = (resp_op == op_read) ? hit_word : '0;

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic reset
);

   // 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

//--- dv/mem_model.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module mem_model (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [1:0]             delay,
   input  logic                   mem_valid,
   input  icache_addr_pkg::addr_t mem_addr,
   output logic                   mem_ready,
   output icache_addr_pkg::word_t mem_rdata,
   output logic                   mem_rdata_valid
);

   import icache_addr_pkg::*;

   localparam int LAST_BEAT = `ICACHE_LINE_WORDS - 1;
   localparam word_t DATA_KEY = 32'hA5A5_0000;

   typedef enum logic [1:0] {
      ph_idle,
      ph_wait,
      ph_accept,
      ph_stream
   } phase_e;

   phase_e     phase;
   logic [1:0] wait_cnt;
   int         beat;
   addr_t      base;

   initial begin
      mem_ready = 1'b0;
      mem_rdata = '0;
      mem_rdata_valid = 1'b0;
   end

   always @(posedge clk) begin
      if (reset) begin
         phase <= ph_idle;
         mem_ready <= 1'b0;
         mem_rdata_valid <= 1'b0;
      end else begin
         mem_rdata_valid <= 1'b0;
         case (phase)
            ph_idle: begin
               if (mem_valid) begin
                  wait_cnt <= delay;
                  phase <= ph_wait;
               end
            end
            ph_wait: begin
               if (wait_cnt == 2'd0) begin
                  mem_ready <= 1'b1;
                  phase <= ph_accept;
               end else begin
                  wait_cnt <= wait_cnt - 2'd1;
               end
            end
            // handshake happens at the end of this cycle
            ph_accept: begin
               mem_ready <= 1'b0;
               base <= mem_addr;
               beat <= 0;
               phase <= ph_stream;
            end
            ph_stream: begin
               mem_rdata_valid <= 1'b1;
               mem_rdata <= (base + addr_t'(beat * 4)) ^ DATA_KEY;
               beat <= beat + 1;
               if (beat == LAST_BEAT) begin
                  phase <= ph_idle;
               end
            end
            default: begin
               phase <= ph_idle;
            end
         endcase
      end
   end

endmodule

//--- dv/icache_tb.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;

   import icache_addr_pkg::*;
   import icache_ctrl_pkg::*;

   localparam word_t DATA_KEY = 32'hA5A5_0000;
   localparam int REQ_TIMEOUT = 20;
   localparam int RESP_TIMEOUT = 200;
   // edges from the edge that raises req_valid to the first sampled resp_valid
   localparam int HIT_LATENCY = 3;
   localparam int INV_LATENCY = 2;

   logic       clk;
   logic       reset;
   cpu_req_t   req;
   logic       req_valid;
   logic       req_ready;
   cpu_resp_t  resp;
   logic       resp_valid;
   logic       resp_ready;
   mem_req_t   mem_req;
   logic       mem_valid;
   logic       mem_ready;
   word_t      mem_rdata;
   logic       mem_rdata_valid;
   logic [1:0] mem_delay;

   logic [31:0] lfsr;
   logic        back_pressure;
   int          mismatches;
   int          protocol_errors;
   int          timeouts;

   // expected cache contents per set and way
   tag_t model_tag [`ICACHE_SETS][`ICACHE_WAYS];
   logic model_valid [`ICACHE_SETS][`ICACHE_WAYS];
   logic model_lru [`ICACHE_SETS];

   tb_clock u_clock (
      .clk   (clk),
      .reset (reset)
   );

   icache_top uut (
      .clk             (clk),
      .reset           (reset),
      .cpu_req         (req),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .cpu_resp        (resp),
      .resp_valid      (resp_valid),
      .resp_ready      (resp_ready),
      .mem_req         (mem_req),
      .mem_valid       (mem_valid),
      .mem_ready       (mem_ready),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid)
   );

   mem_model u_mem (
      .clk             (clk),
      .reset           (reset),
      .delay           (mem_delay),
      .mem_valid       (mem_valid),
      .mem_addr        (mem_req.addr),
      .mem_ready       (mem_ready),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] random_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // memory word holding a byte address
   function automatic word_t expected_word(addr_t a);
      return {a[31:2], 2'b00} ^ DATA_KEY;
   endfunction

   // -1 when the line is not cached
   function automatic int model_way_of(addr_t a);
      int way;
      way = -1;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
         if (model_valid[a[7:4]][w] && model_tag[a[7:4]][w] == a[31:8]) begin
            way = w;
         end
      end
      return way;
   endfunction

   // returns the predicted hit, then applies fill and LRU update
   function automatic logic model_read(addr_t a);
      int   way;
      logic found;
      way = model_way_of(a);
      found = way >= 0;
      if (!found) begin
         way = int'(model_lru[a[7:4]]);
         model_tag[a[7:4]][way] = a[31:8];
         model_valid[a[7:4]][way] = 1'b1;
      end
      // a refill ends in a hit on the filled way
      model_lru[a[7:4]] = (way == 0);
      return found;
   endfunction

   task automatic note_mismatch(string msg);
      mismatches++;
      $display("mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic finish_run();
      $display("checks done: %0d mismatches, %0d protocol errors, %0d timeouts",
               mismatches, protocol_errors, timeouts);
      if (mismatches + protocol_errors + timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   task automatic note_timeout(string what);
      timeouts++;
      $display("timeout at %0t ns: %s", $time, what);
   endtask

   // one full transaction, starts and ends on a rising edge
   task automatic run_req(cache_op_e op, addr_t a, logic exp_hit);
      int          n;
      int          mem_reqs;
      int          latency;
      logic        stalled;
      logic        done;
      logic [31:0] r;
      cpu_resp_t   held;
      // nothing more is sent once the run has stalled
      if (timeouts != 0) begin
         return;
      end
      r = random_bits(2);
      mem_delay <= r[1:0];
      req <= '{op: op, addr: a};
      req_valid <= 1'b1;
      n = 1;
      @(posedge clk);
      while (!req_ready) begin
         if (n >= REQ_TIMEOUT) begin
            note_timeout("request was never accepted");
            return;
         end
         @(posedge clk);
         n++;
      end
      req_valid <= 1'b0;
      mem_reqs = 0;
      latency = 0;
      stalled = 1'b0;
      done = 1'b0;
      held = '0;
      while (!done) begin
         r = random_bits(2);
         resp_ready <= back_pressure ? (r[1:0] == 2'd0) : 1'b1;
         @(posedge clk);
         n++;
         if (n > RESP_TIMEOUT) begin
            note_timeout("no response to the request");
            return;
         end
         assert (!req_ready) else begin
            protocol_errors++;
            $display("req_ready was high at %0t ns while a response was pending", $time);
         end
         if (mem_valid && mem_ready) begin
            mem_reqs++;
            assert (mem_req.addr == {a[31:4], 4'h0}) else
               note_mismatch($sformatf("mem_req addr %h for %h", mem_req.addr, a));
         end
         if (stalled) begin
            assert (resp_valid && resp == held) else
               note_mismatch("response changed while resp_ready was low");
         end
         if (resp_valid && latency == 0) begin
            latency = n;
         end
         stalled = resp_valid && !resp_ready;
         held = resp;
         done = resp_valid && resp_ready;
      end
      if (op == op_read) begin
         assert (held.op == op_read && held.data == expected_word(a)) else
            note_mismatch($sformatf("read %h gave %h, expected %h", a, held.data,
                                    expected_word(a)));
         assert (mem_reqs == (exp_hit ? 0 : 1)) else
            note_mismatch($sformatf("read %h made %0d mem requests", a, mem_reqs));
         if (exp_hit) begin
            assert (latency == HIT_LATENCY) else
               note_mismatch($sformatf("hit on %h took %0d cycles", a, latency));
         end
      end else begin
         assert (held.op == op_invalidate && held.data == '0 && mem_reqs == 0) else
            note_mismatch($sformatf("bad invalidate response for %h", a));
         assert (latency == INV_LATENCY) else
            note_mismatch($sformatf("invalidate of %h took %0d cycles", a, latency));
      end
   endtask

   task automatic read_addr(addr_t a);
      logic exp_hit;
      exp_hit = model_read(a);
      run_req(op_read, a, exp_hit);
   endtask

   // address bit 0 picks the way
   task automatic invalidate_at(addr_t a);
      model_valid[a[7:4]][a[0]] = 1'b0;
      run_req(op_invalidate, a, 1'b0);
   endtask

   task automatic invalidate_line(addr_t a);
      int way;
      way = model_way_of(a);
      invalidate_at({a[31:1], way == 1});
   endtask

   initial begin
      int          n;
      logic [31:0] r;
      logic [3:0]  idx;
      logic [23:0] t;
      addr_t       a_line;
      addr_t       b_line;
      addr_t       c_line;
      lfsr = 32'd98295;
      mismatches = 0;
      protocol_errors = 0;
      timeouts = 0;
      back_pressure = 1'b0;
      req = '0;
      req_valid = 1'b0;
      resp_ready = 1'b0;
      mem_delay = 2'd0;
      for (int s = 0; s < `ICACHE_SETS; s++) begin
         model_lru[s] = 1'b0;
         for (int w = 0; w < `ICACHE_WAYS; w++) begin
            model_valid[s][w] = 1'b0;
         end
      end

      n = 0;
      @(posedge clk);
      while (reset) begin
         if (n >= 10) begin
            note_timeout("reset was never released");
            break;
         end
         @(posedge clk);
         n++;
      end
      assert (!resp_valid && !mem_valid && req_ready) else
         note_mismatch("outputs not idle after reset");

      // three lines in one set
      r = random_bits(4);
      idx = r[3:0];
      r = random_bits(24);
      t = r[23:0];
      a_line = {t, idx, 4'h0};
      b_line = {t ^ 24'h1, idx, 4'h0};
      c_line = {t ^ 24'h2, idx, 4'h0};
      read_addr(a_line | 32'h4);
      read_addr(a_line | 32'h8);
      read_addr(b_line);
      read_addr(a_line);
      // b is now least recently used
      read_addr(c_line | 32'hc);
      read_addr(a_line | 32'h4);
      read_addr(b_line);

      invalidate_line(a_line);
      read_addr(a_line | 32'hc);
      read_addr(b_line | 32'h8);

      // random mix under back-pressure with few tags and sets so lines collide
      back_pressure = 1'b1;
      for (int i = 0; i < 80; i++) begin
         r = random_bits(9);
         a_line = {21'h0A5C3, r[8:6], 2'b10, r[5:4], r[3:0]};
         r = random_bits(3);
         if (r[2:0] == 3'd0) begin
            invalidate_at(a_line);
         end else begin
            read_addr(a_line);
         end
      end

      finish_run();
   end

endmodule

//--- icache.f
+incdir+hdl
hdl/icache_addr_pkg.sv
hdl/icache_ctrl_pkg.sv
hdl/icache_way.sv
hdl/icache_way_select.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
dv/tb_clock.sv
dv/mem_model.sv
dv/icache_tb.sv
